//--- rtl/conv_consts.svh
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// Layer dimensions, their indices and derived input sizes
`define CONV_DIM_W 8

// Kernel size, stride and padding
`define CONV_KER_W 4

// Base and generated addresses
`define CONV_ADDR_W 16

// Input row shift, enough for a ceil(log2) of any CONV_DIM_W value
`define CONV_SHIFT_W 4

// Instruction word, fields from the MSB down:
//   k, s, p           3 x CONV_KER_W
//   of, ox, oy, nif   4 x CONV_DIM_W
//   four bases        4 x CONV_ADDR_W
//   spare             CONV_RSVD_W, zero
`define CONV_INSTR_W 112
`define CONV_RSVD_W 4

`endif

//--- rtl/conv_pkg.sv
`default_nettype none

`include "conv_consts.svh"

package conv_pkg;

  ////////////////////////////////////////
  // Layer instruction word
  ////////////////////////////////////////

  typedef struct packed {
    logic [`CONV_KER_W-1:0]  k;
    logic [`CONV_KER_W-1:0]  s;
    logic [`CONV_KER_W-1:0]  p;
    logic [`CONV_DIM_W-1:0]  of;
    logic [`CONV_DIM_W-1:0]  ox;
    logic [`CONV_DIM_W-1:0]  oy;
    logic [`CONV_DIM_W-1:0]  nif;
    logic [`CONV_ADDR_W-1:0] ifmap_base;
    logic [`CONV_ADDR_W-1:0] weight_base;
    logic [`CONV_ADDR_W-1:0] bias_base;
    logic [`CONV_ADDR_W-1:0] ofmap_base;
    // Spare bits up to the full word
    logic [`CONV_RSVD_W-1:0] rsvd;
  } conv_instr_t;

  // Loop controller states
  typedef enum logic [1:0] {
    S_IDLE = 2'd0,
    S_RUN  = 2'd1,
    S_DONE = 2'd2
  } ctrl_state_e;

  typedef logic [`CONV_ADDR_W-1:0] conv_addr_t;

endpackage

`default_nettype wire

//--- rtl/conv_cfg_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_consts.svh"

// Decoded layer configuration, held from conv_start to the next instruction
interface conv_cfg_if;

  logic [`CONV_KER_W-1:0]   k;
  logic [`CONV_KER_W-1:0]   s;
  logic [`CONV_KER_W-1:0]   p;
  logic [`CONV_DIM_W-1:0]   of;
  logic [`CONV_DIM_W-1:0]   ox;
  logic [`CONV_DIM_W-1:0]   oy;
  logic [`CONV_DIM_W-1:0]   nif;

  // Derived values
  logic [`CONV_DIM_W-1:0]   iy;
  logic [`CONV_DIM_W-1:0]   ix;
  logic [`CONV_SHIFT_W-1:0] ix_shift;
  logic [`CONV_DIM_W-1:0]   kk;
  logic [`CONV_ADDR_W-1:0]  nif_kk;
  logic [`CONV_ADDR_W-1:0]  out_pix;

  logic [`CONV_ADDR_W-1:0]  ifmap_base;
  logic [`CONV_ADDR_W-1:0]  weight_base;
  logic [`CONV_ADDR_W-1:0]  bias_base;
  logic [`CONV_ADDR_W-1:0]  ofmap_base;

  modport decoder (
    output k, s, p, of, ox, oy, nif,
    output iy, ix, ix_shift, kk, nif_kk, out_pix,
    output ifmap_base, weight_base, bias_base, ofmap_base
  );

  modport consumer (
    input k, s, p, of, ox, oy, nif,
    input iy, ix, ix_shift, kk, nif_kk, out_pix,
    input ifmap_base, weight_base, bias_base, ofmap_base
  );

endinterface

`default_nettype wire

//--- rtl/conv_tap_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_consts.svh"

// One convolution tap per clock from the loop controller
interface conv_tap_if;

  logic                   tap_valid;
  logic [`CONV_DIM_W-1:0] of_idx;
  logic [`CONV_DIM_W-1:0] oy_idx;
  logic [`CONV_DIM_W-1:0] ox_idx;
  logic [`CONV_DIM_W-1:0] c_idx;
  logic [`CONV_KER_W-1:0] ky;
  logic [`CONV_KER_W-1:0] kx;
  // Final tap of the current output pixel
  logic                   last_tap;

  modport ctrl (
    output tap_valid, of_idx, oy_idx, ox_idx, c_idx, ky, kx, last_tap
  );

  modport gen (
    input tap_valid, of_idx, oy_idx, ox_idx, c_idx, ky, kx, last_tap
  );

endinterface

`default_nettype wire

//--- rtl/conv_instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_consts.svh"

module conv_instr_decoder import conv_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     conv_decode,
  input  logic [`CONV_INSTR_W-1:0] instr,
  input  logic                     busy,
  output logic                     conv_start,
  conv_cfg_if.decoder              cfg
);

  conv_instr_t              ins;
  logic                     accept;
  logic [`CONV_DIM_W-1:0]   iy_calc;
  logic [`CONV_DIM_W-1:0]   ix_calc;
  logic [`CONV_DIM_W-1:0]   kk_calc;

  // Number of powers of two below v, i.e. ceil(log2(v))
  function automatic logic [`CONV_SHIFT_W-1:0] ceil_log2(input logic [`CONV_DIM_W-1:0] v);
    logic [`CONV_SHIFT_W-1:0] r;
    r = '0;
    for (int i = 0; i < `CONV_DIM_W; i++)
    begin
      if ((32'd1 << i) < 32'(v))
        r = r + 1'b1;
    end
    return r;
  endfunction

  assign ins    = conv_instr_t'(instr);
  assign accept = conv_decode && !busy;

  // Input size covered by the output plane, (o - 1) * s + k - 2p
  assign iy_calc = (ins.oy - 1'b1) * ins.s + ins.k - (ins.p << 1);
  assign ix_calc = (ins.ox - 1'b1) * ins.s + ins.k - (ins.p << 1);
  assign kk_calc = ins.k * ins.k;

  always_ff @(posedge clk)
  begin
    if (reset)
      conv_start <= 1'b0;
    else
      conv_start <= accept;
  end

  ////////////////////////////////////////
  // Layer configuration registers
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cfg.k           <= ins.k;
      cfg.s           <= ins.s;
      cfg.p           <= ins.p;
      cfg.of          <= ins.of;
      cfg.ox          <= ins.ox;
      cfg.oy          <= ins.oy;
      cfg.nif         <= ins.nif;
      cfg.iy          <= iy_calc;
      cfg.ix          <= ix_calc;
      cfg.ix_shift    <= ceil_log2(ix_calc);
      cfg.kk          <= kk_calc;
      cfg.nif_kk      <= ins.nif * kk_calc;
      cfg.out_pix     <= ins.ox * ins.oy;
      cfg.ifmap_base  <= ins.ifmap_base;
      cfg.weight_base <= ins.weight_base;
      cfg.bias_base   <= ins.bias_base;
      cfg.ofmap_base  <= ins.ofmap_base;
    end
  end

  // busy from the controller must block a second start right behind the first
  a_start_single: assert property (@(posedge clk) disable iff (reset)
    conv_start |=> !conv_start);

endmodule

`default_nettype wire

//--- rtl/conv_loop_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_consts.svh"

module conv_loop_ctrl import conv_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         conv_start,
  conv_cfg_if.consumer cfg,
  conv_tap_if.ctrl     tap,
  output logic         busy,
  output logic         conv_done
);

  ctrl_state_e state;

  logic kx_wrap;
  logic ky_wrap;
  logic c_wrap;
  logic ox_wrap;
  logic oy_wrap;
  logic of_wrap;

  // Carry chain, innermost loop first
  logic step_ky;
  logic step_c;
  logic step_ox;
  logic step_oy;
  logic step_of;
  logic final_tap;

  assign kx_wrap = tap.kx == cfg.k - 1'b1;
  assign ky_wrap = tap.ky == cfg.k - 1'b1;
  assign c_wrap  = tap.c_idx == cfg.nif - 1'b1;
  assign ox_wrap = tap.ox_idx == cfg.ox - 1'b1;
  assign oy_wrap = tap.oy_idx == cfg.oy - 1'b1;
  assign of_wrap = tap.of_idx == cfg.of - 1'b1;

  assign step_ky   = kx_wrap;
  assign step_c    = step_ky && ky_wrap;
  assign step_ox   = step_c && c_wrap;
  assign step_oy   = step_ox && ox_wrap;
  assign step_of   = step_oy && oy_wrap;
  assign final_tap = tap.tap_valid && step_of && of_wrap;

  assign tap.last_tap = tap.tap_valid && step_ox;

  // conv_start marks the acceptance edge, the FSM holds busy after that
  assign busy = conv_start || (state != S_IDLE);

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state         <= S_IDLE;
      tap.tap_valid <= 1'b0;
      conv_done     <= 1'b0;
    end
    else
    begin
      conv_done <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (conv_start)
          begin
            state         <= S_RUN;
            tap.tap_valid <= 1'b1;
          end
        end
        S_RUN:
        begin
          if (final_tap)
          begin
            state         <= S_DONE;
            tap.tap_valid <= 1'b0;
          end
        end
        S_DONE:
        begin
          // Last address leaves the generators in this cycle
          state     <= S_IDLE;
          conv_done <= 1'b1;
        end
        default:
          state <= S_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Tap counters
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset || (state == S_IDLE))
    begin
      tap.kx     <= '0;
      tap.ky     <= '0;
      tap.c_idx  <= '0;
      tap.ox_idx <= '0;
      tap.oy_idx <= '0;
      tap.of_idx <= '0;
    end
    else if (tap.tap_valid)
    begin
      tap.kx <= kx_wrap ? '0 : tap.kx + 1'b1;
      if (step_ky)
        tap.ky <= ky_wrap ? '0 : tap.ky + 1'b1;
      if (step_c)
        tap.c_idx <= c_wrap ? '0 : tap.c_idx + 1'b1;
      if (step_ox)
        tap.ox_idx <= ox_wrap ? '0 : tap.ox_idx + 1'b1;
      if (step_oy)
        tap.oy_idx <= oy_wrap ? '0 : tap.oy_idx + 1'b1;
      if (step_of)
        tap.of_idx <= of_wrap ? '0 : tap.of_idx + 1'b1;
    end
  end

  a_idx_bounds: assert property (@(posedge clk) disable iff (reset)
    tap.tap_valid |-> (tap.kx < cfg.k) && (tap.ky < cfg.k) && (tap.c_idx < cfg.nif)
                      && (tap.ox_idx < cfg.ox) && (tap.oy_idx < cfg.oy)
                      && (tap.of_idx < cfg.of));

  a_valid_in_run: assert property (@(posedge clk) disable iff (reset)
    tap.tap_valid |-> state == S_RUN);

endmodule

`default_nettype wire

//--- rtl/ifmap_addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_consts.svh"

module ifmap_addr_gen import conv_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  conv_cfg_if.consumer            cfg,
  conv_tap_if.gen                 tap,
  output logic                    ifmap_rd,
  output logic                    pad_zero,
  output logic [`CONV_ADDR_W-1:0] ifmap_addr
);

  // Input position of the tap, negative inside the top or left padding
  logic signed [`CONV_ADDR_W-1:0] row_pos;
  logic signed [`CONV_ADDR_W-1:0] col_pos;
  logic                           in_pad;
  conv_addr_t                     line;
  conv_addr_t                     addr;

  assign row_pos = $signed(conv_addr_t'(tap.oy_idx) * conv_addr_t'(cfg.s)
                           + conv_addr_t'(tap.ky) - conv_addr_t'(cfg.p));
  assign col_pos = $signed(conv_addr_t'(tap.ox_idx) * conv_addr_t'(cfg.s)
                           + conv_addr_t'(tap.kx) - conv_addr_t'(cfg.p));

  assign in_pad = (row_pos < 0) || (col_pos < 0)
                  || (row_pos >= $signed(conv_addr_t'(cfg.iy)))
                  || (col_pos >= $signed(conv_addr_t'(cfg.ix)));

  // Rows are 2**ix_shift apart, channels iy rows apart
  assign line = conv_addr_t'(tap.c_idx) * conv_addr_t'(cfg.iy) + conv_addr_t'(row_pos);
  assign addr = cfg.ifmap_base + (line << cfg.ix_shift) + conv_addr_t'(col_pos);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ifmap_rd <= 1'b0;
      pad_zero <= 1'b0;
    end
    else
    begin
      ifmap_rd <= tap.tap_valid && !in_pad;
      pad_zero <= tap.tap_valid && in_pad;
    end
  end

  always_ff @(posedge clk)
  begin
    ifmap_addr <= addr;
  end

  // Each tap gives exactly one of read or padding, never both
  a_rd_or_pad: assert property (@(posedge clk) disable iff (reset)
    tap.tap_valid |=> $onehot({ifmap_rd, pad_zero}));

endmodule

`default_nettype wire

//--- rtl/weight_addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_consts.svh"

module weight_addr_gen import conv_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  conv_cfg_if.consumer            cfg,
  conv_tap_if.gen                 tap,
  output logic                    weight_rd,
  output logic [`CONV_ADDR_W-1:0] weight_addr
);

  conv_addr_t filt_off;
  conv_addr_t chan_off;
  conv_addr_t ker_off;

  // Weights laid out as [of][nif][ky][kx]
  assign filt_off = conv_addr_t'(tap.of_idx) * cfg.nif_kk;
  assign chan_off = conv_addr_t'(tap.c_idx) * conv_addr_t'(cfg.kk);
  assign ker_off  = conv_addr_t'(tap.ky) * conv_addr_t'(cfg.k) + conv_addr_t'(tap.kx);

  always_ff @(posedge clk)
  begin
    if (reset)
      weight_rd <= 1'b0;
    else
      weight_rd <= tap.tap_valid;
  end

  always_ff @(posedge clk)
  begin
    weight_addr <= cfg.weight_base + filt_off + chan_off + ker_off;
  end

endmodule

`default_nettype wire

//--- rtl/ofmap_addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_consts.svh"

module ofmap_addr_gen import conv_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  conv_cfg_if.consumer            cfg,
  conv_tap_if.gen                 tap,
  output logic                    ofmap_wr,
  output logic [`CONV_ADDR_W-1:0] bias_addr,
  output logic [`CONV_ADDR_W-1:0] ofmap_addr
);

  logic       pix_done;
  conv_addr_t pix_off;

  assign pix_done = tap.tap_valid && tap.last_tap;

  // Output plane is [of][oy][ox] with out_pix = ox * oy
  assign pix_off = conv_addr_t'(tap.of_idx) * cfg.out_pix
                   + conv_addr_t'(tap.oy_idx) * conv_addr_t'(cfg.ox)
                   + conv_addr_t'(tap.ox_idx);

  always_ff @(posedge clk)
  begin
    if (reset)
      ofmap_wr <= 1'b0;
    else
      ofmap_wr <= pix_done;
  end

  always_ff @(posedge clk)
  begin
    if (pix_done)
    begin
      bias_addr  <= cfg.bias_base + conv_addr_t'(tap.of_idx);
      ofmap_addr <= cfg.ofmap_base + pix_off;
    end
  end

  // Writes only after the final kernel and channel step of a pixel
  a_wr_after_last: assert property (@(posedge clk) disable iff (reset)
    ofmap_wr |-> $past(tap.tap_valid && (tap.kx == cfg.k - 1'b1)
                       && (tap.ky == cfg.k - 1'b1)
                       && (tap.c_idx == cfg.nif - 1'b1)));

endmodule

`default_nettype wire

//--- rtl/conv_layer_seq.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_consts.svh"

module conv_layer_seq import conv_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     conv_decode,
  input  logic [`CONV_INSTR_W-1:0] instr,
  output logic                     conv_start,
  output logic                     busy,
  output logic                     conv_done,
  output logic                     ifmap_rd,
  output logic                     pad_zero,
  output conv_addr_t               ifmap_addr,
  output logic                     weight_rd,
  output conv_addr_t               weight_addr,
  output logic                     ofmap_wr,
  output conv_addr_t               bias_addr,
  output conv_addr_t               ofmap_addr
);

  conv_cfg_if cfg_if ();
  conv_tap_if tap_if ();

  ////////////////////////////////////////
  // Decode and loop control
  ////////////////////////////////////////

  conv_instr_decoder conv_instr_decoder_i (
    .clk         (clk),
    .reset       (reset),
    .conv_decode (conv_decode),
    .instr       (instr),
    .busy        (busy),
    .conv_start  (conv_start),
    .cfg         (cfg_if.decoder)
  );

  conv_loop_ctrl conv_loop_ctrl_i (
    .clk        (clk),
    .reset      (reset),
    .conv_start (conv_start),
    .cfg        (cfg_if.consumer),
    .tap        (tap_if.ctrl),
    .busy       (busy),
    .conv_done  (conv_done)
  );

  ////////////////////////////////////////
  // Address generators
  ////////////////////////////////////////

  ifmap_addr_gen ifmap_addr_gen_i (
    .clk        (clk),
    .reset      (reset),
    .cfg        (cfg_if.consumer),
    .tap        (tap_if.gen),
    .ifmap_rd   (ifmap_rd),
    .pad_zero   (pad_zero),
    .ifmap_addr (ifmap_addr)
  );

  weight_addr_gen weight_addr_gen_i (
    .clk         (clk),
    .reset       (reset),
    .cfg         (cfg_if.consumer),
    .tap         (tap_if.gen),
    .weight_rd   (weight_rd),
    .weight_addr (weight_addr)
  );

  ofmap_addr_gen ofmap_addr_gen_i (
    .clk        (clk),
    .reset      (reset),
    .cfg        (cfg_if.consumer),
    .tap        (tap_if.gen),
    .ofmap_wr   (ofmap_wr),
    .bias_addr  (bias_addr),
    .ofmap_addr (ofmap_addr)
  );

endmodule

`default_nettype wire

//--- verification/conv_layer_seq_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_consts.svh"

module conv_layer_seq_tb;

  // Taps of every layer the tests run
  localparam int tap_total = 2*4*4*2*9 + 2*3*3*2*9 + 4*4*4*3*1 + 2*4*4*2*9
                             + 1*2*2*2*9 + 2*3*3*1*4;
  localparam int layer_count = 6;
  localparam int wd_ns = (tap_total + 20 * layer_count) * 40 + 2000;

  logic                     clk;
  logic                     reset;
  logic                     conv_decode;
  logic [`CONV_INSTR_W-1:0] instr;
  logic                     conv_start;
  logic                     busy;
  logic                     conv_done;
  logic                     ifmap_rd;
  logic                     pad_zero;
  logic [`CONV_ADDR_W-1:0]  ifmap_addr;
  logic                     weight_rd;
  logic [`CONV_ADDR_W-1:0]  weight_addr;
  logic                     ofmap_wr;
  logic [`CONV_ADDR_W-1:0]  bias_addr;
  logic [`CONV_ADDR_W-1:0]  ofmap_addr;

  // Current layer as the reference sees it
  int          lk;
  int          ls;
  int          lp;
  int          lof;
  int          lox;
  int          loy;
  int          lnif;
  int          lix;
  int          liy;
  int          lshift;
  logic [15:0] lib;
  logic [15:0] lwb;
  logic [15:0] lbb;
  logic [15:0] lob;

  // Expected requests in issue order
  // Ifmap entries hold {pad, address}
  logic [16:0] exp_if_q[$];
  logic [15:0] exp_w_q[$];
  logic [15:0] exp_bias_q[$];
  logic [15:0] exp_of_q[$];
  logic [16:0] mon_if_entry;

  int    seed;
  int    cycle;
  int    errors;
  int    err_mark;
  int    tests_run;
  int    exp_pads;
  int    n_pad;
  int    n_w;
  int    n_wr;
  int    n_start;
  int    n_done;
  int    last_req_cycle;
  int    done_cycle;
  string test_name;

  conv_layer_seq conv_layer_seq_i (
    .clk         (clk),
    .reset       (reset),
    .conv_decode (conv_decode),
    .instr       (instr),
    .conv_start  (conv_start),
    .busy        (busy),
    .conv_done   (conv_done),
    .ifmap_rd    (ifmap_rd),
    .pad_zero    (pad_zero),
    .ifmap_addr  (ifmap_addr),
    .weight_rd   (weight_rd),
    .weight_addr (weight_addr),
    .ofmap_wr    (ofmap_wr),
    .bias_addr   (bias_addr),
    .ofmap_addr  (ofmap_addr)
  );

  always #20 clk = ~clk;

  always @(posedge clk)
    cycle <= cycle + 1;

  task automatic report_mismatch(input string what, input int exp, input int act);
    errors++;
    $display("ERROR %s %s: expected %0h actual %0h", test_name, what, exp, act);
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("%s: %s", test_name, msg);
  endtask

  function automatic logic [15:0] random_base();
    int r;
    r = $random(seed);
    return r[15:0];
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Expected {pad, address} of one input access
  function automatic logic [16:0] ifmap_ref(input int oy_i, input int ox_i, input int c,
                                             input int ky, input int kx);
    int row;
    int col;
    int addr;
    row = oy_i * ls + ky - lp;
    col = ox_i * ls + kx - lp;
    if (row < 0 || col < 0 || row >= liy || col >= lix)
      return {1'b1, 16'h0000};
    addr = lib + (((c * liy + row) << lshift) + col);
    return {1'b0, addr[15:0]};
  endfunction

  function automatic logic [15:0] weight_ref(input int of_i, input int c, input int ky,
                                              input int kx);
    int addr;
    addr = lwb + of_i * lnif * lk * lk + c * lk * lk + ky * lk + kx;
    return addr[15:0];
  endfunction

  function automatic logic [15:0] ofmap_ref(input int of_i, input int oy_i, input int ox_i);
    int addr;
    addr = lob + (of_i * loy + oy_i) * lox + ox_i;
    return addr[15:0];
  endfunction

  task automatic set_layer(input int k, input int s, input int p, input int nf,
                           input int ox, input int oy, input int ni,
                           input logic [15:0] ib, input logic [15:0] wb,
                           input logic [15:0] bb, input logic [15:0] ob);
    lk   = k;
    ls   = s;
    lp   = p;
    lof  = nf;
    lox  = ox;
    loy  = oy;
    lnif = ni;
    lib  = ib;
    lwb  = wb;
    lbb  = bb;
    lob  = ob;
    lix  = (ox - 1) * s + k - 2 * p;
    liy  = (oy - 1) * s + k - 2 * p;
    lshift = 0;
    while ((1 << lshift) < lix)
      lshift++;
  endtask

  function automatic logic [`CONV_INSTR_W-1:0] layer_word();
    return {4'(lk), 4'(ls), 4'(lp), 8'(lof), 8'(lox), 8'(loy), 8'(lnif),
            lib, lwb, lbb, lob, 4'h0};
  endfunction

  // Same loop order as the controller from outer to inner
  task automatic build_expected();
    logic [16:0] e;
    exp_pads = 0;
    for (int of_i = 0; of_i < lof; of_i++)
      for (int oy_i = 0; oy_i < loy; oy_i++)
        for (int ox_i = 0; ox_i < lox; ox_i++)
        begin
          for (int c = 0; c < lnif; c++)
            for (int ky = 0; ky < lk; ky++)
              for (int kx = 0; kx < lk; kx++)
              begin
                e = ifmap_ref(oy_i, ox_i, c, ky, kx);
                exp_if_q.push_back(e);
                if (e[16])
                  exp_pads++;
                exp_w_q.push_back(weight_ref(of_i, c, ky, kx));
              end
          exp_bias_q.push_back(16'(lbb + of_i));
          exp_of_q.push_back(ofmap_ref(of_i, oy_i, ox_i));
        end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Entered and left 2 ns after a rising edge
  task automatic run_layer(input logic inject);
    int done_ref;
    int start_ref;
    build_expected();
    done_ref  = n_done;
    start_ref = n_start;
    conv_decode = 1'b1;
    instr = layer_word();
    @(negedge clk);
    if (conv_start)
      report_problem("conv_start rose before the decode was sampled");
    @(posedge clk);
    #2;
    conv_decode = 1'b0;
    @(negedge clk);
    if (!conv_start)
      report_problem("conv_start missing one cycle after conv_decode");
    @(negedge clk);
    if (conv_start)
      report_problem("conv_start lasted more than one cycle");
    if (inject)
    begin
      @(posedge clk);
      #2;
      if (!busy)
        report_problem("busy low while the layer runs");
      // Foreign layer that must not be taken
      conv_decode = 1'b1;
      instr = {4'd2, 4'd2, 4'd0, 8'd3, 8'd3, 8'd3, 8'd3,
               16'hbeef, 16'hbeef, 16'hbeef, 16'hbeef, 4'h0};
      @(posedge clk);
      #2;
      conv_decode = 1'b0;
      instr = layer_word();
    end
    while (n_done == done_ref)
      @(posedge clk);
    repeat (4) @(posedge clk);
    #2;
    if (exp_if_q.size() != 0 || exp_w_q.size() != 0 || exp_of_q.size() != 0)
      report_problem("layer ended with requests still missing");
    if (n_start - start_ref != 1)
      report_mismatch("conv_start count", 1, n_start - start_ref);
    if (done_cycle != last_req_cycle + 1)
      report_mismatch("conv_done cycle", last_req_cycle + 1, done_cycle);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_mark  = errors;
    n_pad     = 0;
    n_w       = 0;
    n_wr      = 0;
  endtask

  task automatic end_test();
    tests_run++;
    $display("%s: %0d weight reads, %0d pads, %0d writes, %0d errors, %s", test_name, n_w,
             n_pad, n_wr, errors - err_mark, (errors == err_mark) ? "ok" : "failed");
  endtask

  ////////////////////////////////////////
  // Monitor and comparison
  ////////////////////////////////////////

  always @(negedge clk)
  begin
    if (!reset)
    begin
      if (conv_start)
        n_start++;
      if (conv_done)
      begin
        n_done++;
        done_cycle = cycle;
      end
      if (ifmap_rd || pad_zero || weight_rd || ofmap_wr)
      begin
        last_req_cycle = cycle;
        if (!busy)
          report_problem("request issued while busy is low");
      end
      if (ifmap_rd && pad_zero)
        report_problem("ifmap_rd and pad_zero high together");
      if (ifmap_rd || pad_zero)
      begin
        if (exp_if_q.size() == 0)
          report_problem("unexpected ifmap request");
        else
        begin
          mon_if_entry = exp_if_q.pop_front();
          if (pad_zero !== mon_if_entry[16])
            report_mismatch("pad_zero", mon_if_entry[16], pad_zero);
          else if (ifmap_rd && ifmap_addr !== mon_if_entry[15:0])
            report_mismatch("ifmap_addr", mon_if_entry[15:0], ifmap_addr);
          if (pad_zero)
            n_pad++;
        end
      end
      if (weight_rd)
      begin
        n_w++;
        if (exp_w_q.size() == 0)
          report_problem("unexpected weight request");
        else if (weight_addr !== exp_w_q[0])
          report_mismatch("weight_addr", exp_w_q.pop_front(), weight_addr);
        else
          void'(exp_w_q.pop_front());
      end
      if (ofmap_wr)
      begin
        n_wr++;
        if (exp_of_q.size() == 0)
          report_problem("unexpected output write");
        else
        begin
          if (bias_addr !== exp_bias_q[0])
            report_mismatch("bias_addr", exp_bias_q[0], bias_addr);
          if (ofmap_addr !== exp_of_q[0])
            report_mismatch("ofmap_addr", exp_of_q[0], ofmap_addr);
          void'(exp_bias_q.pop_front());
          void'(exp_of_q.pop_front());
        end
      end
    end
  end

  initial
  begin
    #(wd_ns);
    $display("Watchdog: the tests did not finish in the expected time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    clk = 1'b0;
    reset = 1'b1;
    conv_decode = 1'b0;
    instr = '0;
    seed = 40024;
    cycle = 0;
    errors = 0;
    tests_run = 0;
    n_start = 0;
    n_done = 0;
    last_req_cycle = 0;
    done_cycle = 0;
    test_name = "reset";
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    @(posedge clk);
    #2;

    begin_test("same3x3");
    set_layer(3, 1, 1, 2, 4, 4, 2, 16'h0000, 16'h1000, 16'h2000, 16'h3000);
    run_layer(1'b0);
    if (n_pad != exp_pads)
      report_mismatch("pad count", exp_pads, n_pad);
    end_test();

    begin_test("stride2");
    set_layer(3, 2, 0, 2, 3, 3, 2, random_base(), random_base(), random_base(),
              random_base());
    run_layer(1'b0);
    if (n_wr != lof * loy * lox)
      report_mismatch("ofmap_wr count", lof * loy * lox, n_wr);
    end_test();

    begin_test("pointwise");
    set_layer(1, 1, 0, 4, 4, 4, 3, 16'h0100, 16'h0200, 16'h0300, 16'h0400);
    run_layer(1'b0);
    if (n_pad != 0)
      report_mismatch("pad count", 0, n_pad);
    if (n_wr != n_w / lnif)
      report_mismatch("ofmap_wr count", n_w / lnif, n_wr);
    end_test();

    begin_test("bias_out");
    set_layer(3, 1, 1, 2, 4, 4, 2, 16'h0400, 16'h0800, 16'h0c40, 16'h7f00);
    run_layer(1'b0);
    if (n_wr != lof * loy * lox)
      report_mismatch("ofmap_wr count", lof * loy * lox, n_wr);
    end_test();

    begin_test("timing_busy");
    set_layer(3, 1, 1, 1, 2, 2, 2, 16'h1100, 16'h2200, 16'h3300, 16'h4400);
    run_layer(1'b1);
    if (n_w != lof * loy * lox * lnif * lk * lk)
      report_mismatch("weight_rd count", lof * loy * lox * lnif * lk * lk, n_w);
    if (busy)
      report_problem("busy still high after conv_done");
    n_w = 0;
    set_layer(2, 1, 0, 2, 3, 3, 1, 16'h5000, 16'h6000, 16'h7000, 16'h8000);
    run_layer(1'b0);
    if (n_w != lof * loy * lox * lnif * lk * lk)
      report_mismatch("weight_rd count", lof * loy * lox * lnif * lk * lk, n_w);
    end_test();

    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- conv_layer_seq.f
+incdir+rtl
rtl/conv_pkg.sv
rtl/conv_cfg_if.sv
rtl/conv_tap_if.sv
rtl/conv_instr_decoder.sv
rtl/conv_loop_ctrl.sv
rtl/ifmap_addr_gen.sv
rtl/weight_addr_gen.sv
rtl/ofmap_addr_gen.sv
rtl/conv_layer_seq.sv
verification/conv_layer_seq_tb.sv
